//--- logic/mem_pkg.sv
/*
 * shared constants for the memory subsystem
 * RAM covers byte addresses 0 .. mem_words*4-1, nothing else is decoded
 * wait_cycles must stay between 1 and 15 (RAM counter is 4 bits)
 */
package mem_pkg;

    // datapath
    localparam int xlen = 32;         // data and address width

    // RAM geometry
    localparam int mem_words   = 512; // 2 KiB of RAM
    localparam int addr_bits   = 9;   // word index width, log2(mem_words)
    localparam int wait_cycles = 2;   // wait states before done

    // func3 codes for loads and stores
    localparam logic [2:0] f3_b  = 3'd0; // LB / SB
    localparam logic [2:0] f3_h  = 3'd1; // LH / SH
    localparam logic [2:0] f3_w  = 3'd2; // LW / SW
    localparam logic [2:0] f3_bu = 3'd4; // LBU
    localparam logic [2:0] f3_hu = 3'd5; // LHU

    // slot sequencer states
    // data phase runs first, fetch closes the slot
    typedef enum logic [1:0] {
        st_data       = 2'd0, // sample core request, freeze low here only
        st_data_wait  = 2'd1, // load/store in flight
        st_fetch      = 2'd2, // strobe instruction read
        st_fetch_wait = 2'd3  // fetch in flight
    } slot_state_t;

endpackage

//--- logic/load_format.sv
/*
 * load lane select and extension, purely combinational
 * halfword lane follows byte_off[1], so byte_off[0] is ignored for LH/LHU
 * no misaligned-access detection
 */
`timescale 1ns/1ps

module load_format import mem_pkg::*; (
    input  logic [xlen-1:0] rdata,    // raw word from RAM
    input  logic [1:0]      byte_off, // low address bits of the access
    input  logic [2:0]      func3,
    output logic [xlen-1:0] value     // extended result for the register file
);

    logic [xlen-1:0] byte_shift; // addressed byte moved to bits 7:0
    logic [xlen-1:0] half_shift; // addressed halfword moved to bits 15:0
    logic [7:0]      lane_b;
    logic [15:0]     lane_h;

    // shift the wanted lane down to bit 0
    assign byte_shift = rdata >> {byte_off, 3'b000};
    assign half_shift = rdata >> {byte_off[1], 4'b0000};

    assign lane_b = byte_shift[7:0];
    assign lane_h = half_shift[15:0];

    always_comb begin
        case (func3)
            f3_b: begin
                value = {{24{lane_b[7]}}, lane_b};   // sign from bit 7
            end
            f3_h: begin
                value = {{16{lane_h[15]}}, lane_h};  // sign from bit 15
            end
            f3_bu: begin
                value = {24'b0, lane_b};
            end
            f3_hu: begin
                value = {16'b0, lane_h};
            end
            default: begin
                value = rdata; // LW and anything unknown pass the word
            end
        endcase
    end

endmodule

//--- logic/store_format.sv
/*
 * store lane replication and byte enables, combinational
 * store value is never sign extended, only the low byte/half is used
 * unknown func3 gives be = 0 so nothing is written
 */
`timescale 1ns/1ps

module store_format import mem_pkg::*; (
    input  logic [xlen-1:0] wdata,     // register value to store
    input  logic [1:0]      byte_off,  // low address bits
    input  logic [2:0]      func3,
    output logic [xlen-1:0] lane_data, // value replicated over all lanes
    output logic [3:0]      be         // one enable per byte lane
);

    always_comb begin
        case (func3)
            f3_b: begin
                lane_data = {4{wdata[7:0]}};
                be        = 4'b0001 << byte_off; // single lane
            end
            f3_h: begin
                lane_data = {2{wdata[15:0]}};
                // lower or upper half, bit 0 ignored
                be = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            f3_w: begin
                lane_data = wdata;
                be        = 4'b1111;
            end
            default: begin
                lane_data = wdata;
                be        = 4'b0000; // SD-like or bad code, drop the store
            end
        endcase
    end

endmodule

//--- logic/mem_handler.sv
/*
 * slot sequencer: optional load/store, then instruction fetch at counter
 * core must hold read, write, func3, address and data while freeze is high
 * addresses at or above mem_words*4 skip the data phase silently
 */
`timescale 1ns/1ps

module mem_handler import mem_pkg::*; (
    input  logic            clk,
    input  logic            nrst,
    // core side
    input  logic            read,
    input  logic            write,
    input  logic [2:0]      func3,
    input  logic [xlen-1:0] mem_address,
    input  logic [xlen-1:0] counter,     // program counter
    // from the formatters
    input  logic [xlen-1:0] lane_data,
    input  logic [3:0]      be,
    input  logic [xlen-1:0] loaded,      // load_format result
    // RAM side
    input  logic            busy,
    input  logic            done,
    input  logic [xlen-1:0] mem_rdata,
    output logic            mem_read,    // one-cycle strobe
    output logic            mem_write,   // one-cycle strobe
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_wdata,
    output logic [3:0]      mem_be,
    // registered request info for load_format
    output logic [1:0]      req_off,
    output logic [2:0]      req_func3,
    // back to the core
    output logic [xlen-1:0] load_data,
    output logic [xlen-1:0] instruction,
    output logic            freeze
);

    slot_state_t state;

    logic req_wr;      // access in flight is a store
    logic in_range;    // address inside RAM
    logic want_access; // core asks for a legal load or store
    logic start_data;  // strobe the data access next cycle
    logic skip_data;   // nothing to do, go fetch
    logic start_fetch; // strobe the fetch next cycle

    // only the RAM range is decoded
    assign in_range    = mem_address < xlen'(mem_words * 4);
    assign want_access = (read | write) & in_range;

    // new strobes only when the RAM is idle
    assign start_data  = (state == st_data) && !busy && want_access;
    assign skip_data   = (state == st_data) && !busy && !want_access;
    assign start_fetch = (state == st_fetch) && !busy;

    assign freeze = (state != st_data); // core runs only between slots

    // control and captured results
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= st_fetch; // first slot starts with a fetch
            mem_read    <= 1'b0;
            mem_write   <= 1'b0;
            req_wr      <= 1'b0;
            load_data   <= '0;
            instruction <= '0;
        end else begin
            mem_read  <= 1'b0; // strobes drop after one cycle
            mem_write <= 1'b0;

            case (state)
                st_data: begin
                    if (start_data) begin
                        mem_write <= write;
                        mem_read  <= ~write; // store wins over load
                        req_wr    <= write;
                        state     <= st_data_wait;
                    end else if (skip_data) begin
                        state <= st_fetch; // load_data left alone
                    end
                end
                st_data_wait: begin
                    if (done) begin
                        if (!req_wr) begin
                            load_data <= loaded; // formatted load result
                        end
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (start_fetch) begin
                        mem_read <= 1'b1;
                        state    <= st_fetch_wait;
                    end
                end
                st_fetch_wait: begin
                    if (done) begin
                        instruction <= mem_rdata; // raw word, no formatting
                        state       <= st_data;
                    end
                end
                default: begin
                    state <= st_fetch;
                end
            endcase
        end
    end

    // request payload, held until the next request
    always_ff @(posedge clk) begin
        if (start_data) begin
            mem_addr  <= mem_address;
            mem_wdata <= lane_data;
            mem_be    <= write ? be : 4'b0000; // loads never enable lanes
            req_off   <= mem_address[1:0];
            req_func3 <= func3;
        end else if (start_fetch) begin
            mem_addr <= counter;
            mem_be   <= 4'b0000;
            // req_off / req_func3 kept, load_data is not captured on fetch
        end
    end

endmodule

//--- logic/wait_state_ram.sv
/*
 * word RAM model with byte enables and fixed wait states
 * strobe at t -> done at t+wait_cycles+1, strobes while busy are ignored
 * address wraps inside mem_words, contents start at zero
 */
`timescale 1ns/1ps

module wait_state_ram import mem_pkg::*; (
    input  logic            clk,
    input  logic            nrst,
    input  logic            mem_read,
    input  logic            mem_write,
    input  logic [xlen-1:0] mem_addr,  // byte address, bits 1:0 ignored
    input  logic [xlen-1:0] mem_wdata,
    input  logic [3:0]      mem_be,
    output logic [xlen-1:0] mem_rdata, // valid in the done cycle
    output logic            busy,
    output logic            done
);

    logic [xlen-1:0] mem [mem_words] = '{default: '0};

    logic [addr_bits-1:0] req_idx;   // latched word index
    logic [xlen-1:0]      req_wdata;
    logic [3:0]           req_be;
    logic                 req_wr;    // latched access is a write
    logic [3:0]           cnt;       // wait states left
    logic                 accept;    // take a new request
    logic                 fire;      // perform access, done next cycle

    assign accept = !busy && (mem_read || mem_write);
    assign fire   = busy && !done && (cnt == 4'd1);

    // handshake and wait counter
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            req_wr <= 1'b0;
            cnt    <= '0;
        end else begin
            if (accept) begin
                busy   <= 1'b1;
                req_wr <= mem_write; // write wins if both strobes set
                cnt    <= 4'(wait_cycles);
            end else if (done) begin
                busy <= 1'b0;        // done cycle is the last busy cycle
                done <= 1'b0;
            end else if (fire) begin
                done <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt - 4'd1;
            end
        end
    end

    // array access and request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_idx   <= mem_addr[addr_bits+1:2];
            req_wdata <= mem_wdata;
            req_be    <= mem_be;
        end
        if (fire) begin
            if (req_wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_be[b]) begin
                        mem[req_idx][8*b +: 8] <= req_wdata[8*b +: 8];
                    end
                end
            end else begin
                mem_rdata <= mem[req_idx];
            end
        end
    end

endmodule

//--- logic/mem_subsys_top.sv
/*
 * memory side of the core: handler, load/store formatters and RAM
 * one access plus one fetch per slot, freeze high until the slot ends
 */
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
    input  logic            clk,
    input  logic            nrst,
    input  logic            read,
    input  logic            write,
    input  logic [2:0]      func3,
    input  logic [xlen-1:0] mem_address,
    input  logic [xlen-1:0] store_data,
    input  logic [xlen-1:0] counter,
    output logic [xlen-1:0] load_data,
    output logic [xlen-1:0] instruction,
    output logic            freeze
);

    // handler <-> RAM
    logic            mem_read;
    logic            mem_write;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] mem_wdata;
    logic [3:0]      mem_be;
    logic [xlen-1:0] mem_rdata;
    logic            busy;
    logic            done;

    // formatter paths
    logic [xlen-1:0] lane_data; // replicated store value
    logic [3:0]      be;
    logic [1:0]      req_off;
    logic [2:0]      req_func3;
    logic [xlen-1:0] loaded;    // extended load value

    // store side sees the live core request
    store_format u_store (
        .wdata     (store_data),
        .byte_off  (mem_address[1:0]),
        .func3     (func3),
        .lane_data (lane_data),
        .be        (be)
    );

    // load side sees the registered request
    load_format u_load (
        .rdata    (mem_rdata),
        .byte_off (req_off),
        .func3    (req_func3),
        .value    (loaded)
    );

    mem_handler u_handler (
        .clk         (clk),
        .nrst        (nrst),
        .read        (read),
        .write       (write),
        .func3       (func3),
        .mem_address (mem_address),
        .counter     (counter),
        .lane_data   (lane_data),
        .be          (be),
        .loaded      (loaded),
        .busy        (busy),
        .done        (done),
        .mem_rdata   (mem_rdata),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_be      (mem_be),
        .req_off     (req_off),
        .req_func3   (req_func3),
        .load_data   (load_data),
        .instruction (instruction),
        .freeze      (freeze)
    );

    wait_state_ram u_ram (
        .clk       (clk),
        .nrst      (nrst),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_be    (mem_be),
        .mem_rdata (mem_rdata),
        .busy      (busy),
        .done      (done)
    );

endmodule

//--- test/tb_clock.sv
/*
 * clock and reset source for the testbench, 10 ns period
 * nrst is released on a rising edge once reset_cycles edges have passed
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic nrst
);

    localparam int reset_cycles = 10; // rising edges with nrst low

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 100 MHz
    end

    initial begin
        nrst <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        nrst <= 1'b1; // flops still see reset on this edge
    end

endmodule

//--- test/tb_mem_subsys.sv
/*
 * testbench for mem_subsys_top against a byte-wide shadow of the RAM
 * a request driven at the end of one freeze-low cycle is taken at the next data phase,
 * while the slot starting on that edge already fetches at the new counter
 * only aligned halfword and word accesses are generated, counter stays in RAM
 */
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

    localparam int          window_timeout = 50;  // cycles allowed per slot
    localparam int          reset_timeout  = 20;
    localparam int          random_slots   = 200;
    localparam logic [31:0] ram_top        = 32'(mem_words * 4); // first unmapped byte

    logic        clk;
    logic        nrst;
    logic        read;
    logic        write;
    logic [2:0]  func3;
    logic [31:0] mem_address;
    logic [31:0] store_data;
    logic [31:0] counter;
    logic [31:0] load_data;
    logic [31:0] instruction;
    logic        freeze;

    logic [7:0]  shadow [mem_words * 4] = '{default: 8'h00}; // byte image of the RAM
    logic [31:0] exp_load;   // load_data due at the next freeze-low cycle
    logic [31:0] exp_instr;  // instruction due at the same point
    logic [31:0] model_load; // load_data once the last driven request has run
    logic [8:0]  pc_idx;     // fetch word index, walks through the RAM

    tb_clock u_clock (
        .clk  (clk),
        .nrst (nrst)
    );

    mem_subsys_top u_dut (
        .clk         (clk),
        .nrst        (nrst),
        .read        (read),
        .write       (write),
        .func3       (func3),
        .mem_address (mem_address),
        .store_data  (store_data),
        .counter     (counter),
        .load_data   (load_data),
        .instruction (instruction),
        .freeze      (freeze)
    );

    // little-endian word holding byte a
    function automatic logic [31:0] word_at(input logic [10:0] a);
        logic [10:0] base;
        base = {a[10:2], 2'b00};
        return {shadow[base + 11'd3], shadow[base + 11'd2],
                shadow[base + 11'd1], shadow[base]};
    endfunction

    // RV32I load rule: pick the lane, then sign or zero extend
    function automatic logic [31:0] load_model(input logic [2:0] f3, input logic [10:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = shadow[a];
        h = {shadow[{a[10:1], 1'b1}], shadow[{a[10:1], 1'b0}]};
        case (f3)
            f3_b:    return {{24{b[7]}}, b};
            f3_h:    return {{16{h[15]}}, h};
            f3_bu:   return {24'h0, b};
            f3_hu:   return {16'h0, h};
            default: return word_at(a); // LW and unknown codes
        endcase
    endfunction

    // SB, SH, SW write only their own bytes, other codes write nothing
    task automatic store_model(input logic [2:0] f3, input logic [10:0] a,
                               input logic [31:0] d);
        logic [10:0] base;
        base = {a[10:2], 2'b00};
        case (f3)
            f3_b: shadow[a] = d[7:0];
            f3_h: begin
                shadow[{a[10:1], 1'b0}] = d[7:0];
                shadow[{a[10:1], 1'b1}] = d[15:8];
            end
            f3_w: begin
                shadow[base]          = d[7:0];
                shadow[base + 11'd1]  = d[15:8];
                shadow[base + 11'd2]  = d[23:16];
                shadow[base + 11'd3]  = d[31:24];
            end
            default: ; // no lane enabled
        endcase
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // returns at the falling edge of a freeze-low cycle
    task automatic wait_window();
        int n;
        n = 0;
        @(negedge clk);
        while (freeze !== 1'b0) begin
            n++;
            if (n >= window_timeout) begin
                $display("freeze never fell within %0d cycles", window_timeout);
                $display("test failed");
                $fatal(1, "freeze timeout");
            end
            @(negedge clk);
        end
    endtask

    // check the slot just ended, then hand over the next request
    task automatic run_slot(input logic rd, input logic wr, input logic [2:0] f3,
                            input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] pc;
        wait_window();
        check_value("load_data", load_data, exp_load);
        check_value("instruction", instruction, exp_instr);
        pc     = {21'h0, pc_idx, 2'b00};
        pc_idx = pc_idx + 9'd1;
        @(posedge clk);
        read        <= rd;
        write       <= wr;
        func3       <= f3;
        mem_address <= addr;
        store_data  <= data;
        counter     <= pc;
        // slot starting now: previous request's data, then fetch at pc
        exp_load  = model_load;
        exp_instr = word_at(pc[10:0]);
        // this request runs in the following slot, out of range is skipped
        if ((rd || wr) && addr < ram_top) begin
            if (wr) begin
                store_model(f3, addr[10:0], data);
            end else begin
                model_load = load_model(f3, addr[10:0]);
            end
        end
    endtask

    task automatic store_op(input logic [2:0] f3, input logic [31:0] addr,
                            input logic [31:0] data);
        run_slot(1'b0, 1'b1, f3, addr, data);
    endtask

    task automatic load_op(input logic [2:0] f3, input logic [31:0] addr);
        run_slot(1'b1, 1'b0, f3, addr, $urandom()); // store_data is noise here
    endtask

    task automatic fetch_at(input logic [31:0] pc);
        pc_idx = pc[10:2];
        run_slot(1'b0, 1'b0, f3_w, '0, '0);
    endtask

    task automatic random_slot();
        int          kind;
        int          sel;
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] addr;
        logic [2:0]  f3;
        kind = $urandom_range(0, 9);
        sel  = $urandom_range(0, 4);
        r    = $urandom();
        hi   = $urandom();
        case (sel)
            0:       f3 = f3_b;
            1:       f3 = f3_h;
            2:       f3 = f3_w;
            3:       f3 = f3_bu;
            default: f3 = f3_hu;
        endcase
        addr = {21'h0, r[10:0]};
        case (f3)
            f3_h, f3_hu: addr[1:0] = {r[1], 1'b0}; // halfword aligned
            f3_w:        addr[1:0] = 2'b00;
            default:     addr[1:0] = r[1:0];
        endcase
        if (r[31:28] < 4'd3) begin
            addr[31:11] = hi[20:0] | 21'd1; // about one in five beyond the RAM
        end
        if (kind < 2) begin
            run_slot(1'b0, 1'b0, f3, addr, $urandom());
        end else if (kind < 6) begin
            load_op(f3, addr);
        end else begin
            store_op(f3, addr, $urandom()); // bu/hu codes act as null stores
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'h25383423));
        read        <= 1'b0;
        write       <= 1'b0;
        func3       <= 3'd0;
        mem_address <= '0;
        store_data  <= '0;
        counter     <= '0; // reset slot fetches word 0
        exp_load   = '0;
        exp_instr  = '0;
        model_load = '0;
        pc_idx     = 9'd1;

        // outputs held through reset and just after release
        n = 0;
        do begin
            @(negedge clk);
            check_value("freeze", {31'b0, freeze}, 32'd1);
            check_value("load_data", load_data, '0);
            check_value("instruction", instruction, '0);
            n++;
            if (n > reset_timeout) begin
                $display("nrst was never released within %0d cycles", reset_timeout);
                $display("test failed");
                $fatal(1, "reset timeout");
            end
        end while (nrst !== 1'b1);

        // byte enables merge into one word, func3 3 drops the store
        store_op(f3_w, 32'h0000_0040, 32'h1122_3344);
        load_op(f3_w, 32'h0000_0040);
        store_op(f3_h, 32'h0000_0042, 32'haaaa_beef);
        store_op(f3_b, 32'h0000_0041, 32'h5a5a_5a7c);
        store_op(f3_h, 32'h0000_0040, 32'h0000_c3d2);
        store_op(f3_b, 32'h0000_0043, 32'h0000_0091);
        load_op(f3_w, 32'h0000_0040);
        store_op(3'd3, 32'h0000_0040, 32'hffff_ffff);
        load_op(f3_w, 32'h0000_0040);

        // every legal lane, both sign polarities in bytes and halves
        store_op(f3_w, 32'h0000_0080, 32'h8001_7ffe);
        store_op(f3_w, 32'h0000_0084, 32'h7f80_ff01);
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                load_op(f3_b, 32'h0000_0080 + 32'(4 * w + off));
                load_op(f3_bu, 32'h0000_0080 + 32'(4 * w + off));
                if (off % 2 == 0) begin
                    load_op(f3_h, 32'h0000_0080 + 32'(4 * w + off));
                    load_op(f3_hu, 32'h0000_0080 + 32'(4 * w + off));
                end
            end
        end

        // fetches see the stored words
        fetch_at(32'h0000_0040);
        fetch_at(32'h0000_0080);
        fetch_at(32'h0000_0084);

        // beyond 2 KiB, the RAM would alias these to low words
        load_op(f3_w, 32'h0000_0084);
        load_op(f3_w, 32'h0000_0880);
        store_op(f3_w, 32'h0000_0840, 32'hdead_beef);
        store_op(f3_b, 32'hffff_ffff, 32'h0000_00aa);
        load_op(f3_hu, 32'h0000_0800);
        load_op(f3_w, 32'h0000_0040);
        load_op(f3_w, 32'h0000_07fc);
        fetch_at(32'h0000_0040);

        for (int i = 0; i < random_slots; i++) begin
            random_slot();
        end

        // last request runs in this idle slot
        run_slot(1'b0, 1'b0, f3_w, '0, '0);
        wait_window();
        check_value("load_data", load_data, exp_load);
        check_value("instruction", instruction, exp_instr);
        $display("test passed");
        $finish;
    end

endmodule

//--- sim.f
logic/mem_pkg.sv
logic/load_format.sv
logic/store_format.sv
logic/mem_handler.sv
logic/wait_state_ram.sv
logic/mem_subsys_top.sv
test/tb_clock.sv
test/tb_mem_subsys.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_mem_subsys
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

# build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
